/* verilog/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath word width
`define EXEC_WORD_W 32

// One divider step per quotient bit
`define EXEC_DIV_STEPS 32

// EFLAGS bit positions, x86 layout
`define EXEC_CF_BIT 0
`define EXEC_PF_BIT 2
`define EXEC_AF_BIT 4
`define EXEC_ZF_BIT 6
`define EXEC_SF_BIT 7
`define EXEC_DF_BIT 10
`define EXEC_OF_BIT 11

`endif

/* verilog/exec_pkg.sv */
`include "exec_params.svh"

package exec_pkg;

  // Command codes as issued by decode
  typedef enum logic [6:0] {
    CMD_NOP  = 7'd0,
    CMD_ADD,
    CMD_ADC,
    CMD_INC,
    CMD_SUB,
    CMD_SBB,
    CMD_DEC,
    CMD_CMP,
    CMD_AND,
    CMD_OR,
    CMD_XOR,
    CMD_NOT,
    CMD_TEST,
    CMD_SHL,
    CMD_SHR,
    CMD_ROL,
    CMD_ROR,
    CMD_PUSH,
    CMD_POP,
    CMD_CALL,
    CMD_RET,
    CMD_LOOP,
    CMD_MOV,
    CMD_XCHG,
    CMD_CDQ,
    CMD_STC,
    CMD_CLC,
    CMD_STD,
    CMD_CLD,
    CMD_LAHF,
    CMD_SAHF,
    CMD_JMP,
    CMD_JZ,
    CMD_JNZ,
    CMD_JC,
    CMD_DIV
  } exec_cmd_e;

  // Named EFLAGS fields, MSB first
  typedef struct packed {
    logic [`EXEC_WORD_W-`EXEC_OF_BIT-2:0] upper;
    logic of;
    logic df;
    logic intf;
    logic tf;
    logic sf;
    logic zf;
    logic rsvd5;
    logic af;
    logic rsvd3;
    logic pf;
    logic rsvd1;
    logic cf;
  } eflags_fields_t;

  // Same word seen raw or by flag
  typedef union packed {
    logic [`EXEC_WORD_W-1:0] raw;
    eflags_fields_t          fields;
  } eflags_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOT,
    ALU_SHL,
    ALU_SHR,
    ALU_ROL,
    ALU_ROR,
    ALU_PASS
  } alu_op_e;

endpackage

/* verilog/exec_opnd_if.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

// Latched command and read operands, shared by all data units
interface exec_opnd_if import exec_pkg::*; ();
  exec_cmd_e               cmd;
  eflags_u                 eflags;
  logic [`EXEC_WORD_W-1:0] eip;
  logic [3:0]              instr_len;
  logic                    ecx_is_zero;
  logic [`EXEC_WORD_W-1:0] opnd0;
  logic [`EXEC_WORD_W-1:0] opnd1;
  logic [`EXEC_WORD_W-1:0] opnd2;

  // Sequencer owns the latch
  modport seq (output cmd, eflags, eip, instr_len, ecx_is_zero, opnd0, opnd1, opnd2);

  modport unit (input cmd, eflags, eip, instr_len, ecx_is_zero, opnd0, opnd1, opnd2);
endinterface

/* verilog/exec_seq.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module exec_seq import exec_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  exec_cmd_e               cmd,
  input  logic [`EXEC_WORD_W-1:0] eflags,
  input  logic [`EXEC_WORD_W-1:0] eip,
  input  logic [3:0]              instr_len,
  input  logic                    ecx_is_zero,
  input  logic [`EXEC_WORD_W-1:0] opnd0_r,
  input  logic [`EXEC_WORD_W-1:0] opnd1_r,
  input  logic [`EXEC_WORD_W-1:0] opnd2_r,
  input  logic                    div_last,
  exec_opnd_if.seq                opnd,
  output logic                    div_load,
  output logic                    div_step,
  output logic                    capture,
  output logic                    busy
);

  typedef enum logic [1:0] {
    IDLE,
    DIV_LOAD,
    DIV_RUN,
    FINISH
  } state_e;

  state_e state;
  logic   accept;

  // Only an idle sequencer takes a new command
  assign accept = (state == IDLE) && start;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= (cmd == CMD_DIV) ? DIV_LOAD : FINISH;
          end
        end
        DIV_LOAD: state <= DIV_RUN;
        // Counter says when the final step is taken
        DIV_RUN: begin
          if (div_last) begin
            state <= FINISH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operand latch, held until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      opnd.cmd         <= cmd;
      opnd.eflags.raw  <= eflags;
      opnd.eip         <= eip;
      opnd.instr_len   <= instr_len;
      opnd.ecx_is_zero <= ecx_is_zero;
      opnd.opnd0       <= opnd0_r;
      opnd.opnd1       <= opnd1_r;
      opnd.opnd2       <= opnd2_r;
    end
  end

  assign div_load = (state == DIV_LOAD);
  assign div_step = (state == DIV_RUN);
  // Results settle one cycle before done
  assign capture  = (state == FINISH);
  assign busy     = (state != IDLE);

endmodule

/* verilog/div_step_counter.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module div_step_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic step,
  output logic last
);

  localparam int CNT_W = $clog2(`EXEC_DIV_STEPS + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= CNT_W'(`EXEC_DIV_STEPS);
    end else if (step && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  // High while the final step is pending
  assign last = (count == CNT_W'(1));

endmodule

/* verilog/alu.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module alu import exec_pkg::*; (
  input  alu_op_e                 op,
  exec_opnd_if.unit               opnd,
  input  logic                    use_carry,
  input  logic                    adjust,
  output logic [`EXEC_WORD_W-1:0] result,
  output eflags_u                 flags
);

  localparam int W = `EXEC_WORD_W;

  logic [W-1:0] a;
  logic [W-1:0] b;
  logic         cin;
  logic [W:0]   sum;
  logic [W:0]   diff;
  logic [4:0]   cnt;
  logic [W:0]   shl_ext;
  logic [W:0]   shr_ext;
  logic [W-1:0] rol_res;
  logic [W-1:0] ror_res;
  logic         upd_zsp;
  logic         logic_op;

  // Adjusts work on the stack or ECX value and its step size
  assign a = adjust ? opnd.opnd1 : opnd.opnd0;
  assign b = adjust ? opnd.opnd2 : opnd.opnd1;

  // Carry in for ADC, borrow in for SBB
  assign cin  = use_carry & opnd.eflags.fields.cf;
  assign sum  = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, cin};
  assign diff = {1'b0, a} - {1'b0, b} - {{W{1'b0}}, cin};

  // Shift count is the low five bits of the source
  assign cnt = opnd.opnd1[4:0];
  // Extra bit catches the last bit shifted out
  assign shl_ext = {1'b0, a} << cnt;
  assign shr_ext = {a, 1'b0} >> cnt;
  assign rol_res = (a << cnt) | (a >> (W - int'(cnt)));
  assign ror_res = (a >> cnt) | (a << (W - int'(cnt)));

  always_comb begin
    result   = a;
    flags    = opnd.eflags;
    upd_zsp  = 1'b0;
    logic_op = 1'b0;
    case (op)
      ALU_ADD: begin
        result          = sum[W-1:0];
        flags.fields.cf = sum[W];
        flags.fields.of = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
        upd_zsp         = 1'b1;
      end
      ALU_SUB: begin
        // CF is the borrow out
        result          = diff[W-1:0];
        flags.fields.cf = diff[W];
        flags.fields.of = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
        upd_zsp         = 1'b1;
      end
      ALU_AND: begin
        result   = a & b;
        logic_op = 1'b1;
      end
      ALU_OR: begin
        result   = a | b;
        logic_op = 1'b1;
      end
      ALU_XOR: begin
        result   = a ^ b;
        logic_op = 1'b1;
      end
      // NOT touches no flags
      ALU_NOT: result = ~a;
      ALU_SHL: begin
        result = shl_ext[W-1:0];
        if (cnt != 5'd0) begin
          flags.fields.cf = shl_ext[W];
          upd_zsp         = 1'b1;
        end
      end
      ALU_SHR: begin
        result = shr_ext[W:1];
        if (cnt != 5'd0) begin
          flags.fields.cf = shr_ext[0];
          upd_zsp         = 1'b1;
        end
      end
      // Rotates only move CF
      ALU_ROL: begin
        result = rol_res;
        if (cnt != 5'd0) begin
          flags.fields.cf = rol_res[0];
        end
      end
      ALU_ROR: begin
        result = ror_res;
        if (cnt != 5'd0) begin
          flags.fields.cf = ror_res[W-1];
        end
      end
      default: result = a;
    endcase

    if (logic_op) begin
      flags.fields.cf = 1'b0;
      flags.fields.of = 1'b0;
      upd_zsp         = 1'b1;
    end
    if (upd_zsp) begin
      flags.fields.zf = (result == '0);
      flags.fields.sf = result[W-1];
      // Even parity over the low byte
      flags.fields.pf = ~^result[7:0];
    end
    // Stack and ECX adjusts keep the incoming flags
    if (adjust) begin
      flags = opnd.eflags;
    end
  end

endmodule

/* verilog/div_unit.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module div_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load,
  input  logic                    step,
  exec_opnd_if.unit               opnd,
  output logic [`EXEC_WORD_W-1:0] quotient,
  output logic [`EXEC_WORD_W-1:0] remainder
);

  localparam int W = `EXEC_WORD_W;

  logic [W:0] partial;
  logic [W:0] trial;
  logic       fits;

  // Next partial remainder takes the top dividend bit
  assign partial = {remainder, quotient[W-1]};
  assign trial   = partial - {1'b0, opnd.opnd1};
  // Zero divisor always fits, which gives all ones
  assign fits    = (partial >= {1'b0, opnd.opnd1});

  // Quotient register starts as the dividend and shifts out at the top
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      quotient  <= '0;
      remainder <= '0;
    end else if (load) begin
      quotient  <= opnd.opnd0;
      remainder <= '0;
    end else if (step) begin
      if (fits) begin
        remainder <= trial[W-1:0];
        quotient  <= {quotient[W-2:0], 1'b1};
      end else begin
        // Restore, keep the shifted remainder
        remainder <= partial[W-1:0];
        quotient  <= {quotient[W-2:0], 1'b0};
      end
    end
  end

endmodule

/* verilog/move_flag_unit.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module move_flag_unit import exec_pkg::*; (
  exec_opnd_if.unit               opnd,
  output logic [`EXEC_WORD_W-1:0] opnd0_w,
  output logic [`EXEC_WORD_W-1:0] opnd1_w,
  output eflags_u                 flags
);

  logic [7:0] ah;

  // AH image of the low flag byte, bit 1 reads as one
  always_comb begin
    ah                = 8'b0000_0010;
    ah[`EXEC_SF_BIT] = opnd.eflags.fields.sf;
    ah[`EXEC_ZF_BIT] = opnd.eflags.fields.zf;
    ah[`EXEC_AF_BIT] = opnd.eflags.fields.af;
    ah[`EXEC_PF_BIT] = opnd.eflags.fields.pf;
    ah[`EXEC_CF_BIT] = opnd.eflags.fields.cf;
  end

  always_comb begin
    opnd0_w = opnd.opnd0;
    opnd1_w = opnd.opnd1;
    flags   = opnd.eflags;
    case (opnd.cmd)
      CMD_MOV: opnd0_w = opnd.opnd1;
      CMD_XCHG: begin
        opnd0_w = opnd.opnd1;
        opnd1_w = opnd.opnd0;
      end
      // Sign of EAX spread over EDX
      CMD_CDQ: opnd1_w = {`EXEC_WORD_W{opnd.opnd0[`EXEC_WORD_W-1]}};
      CMD_STC: flags.fields.cf = 1'b1;
      CMD_CLC: flags.fields.cf = 1'b0;
      CMD_STD: flags.fields.df = 1'b1;
      CMD_CLD: flags.fields.df = 1'b0;
      CMD_LAHF: opnd0_w[15:8] = ah;
      CMD_SAHF: begin
        flags.fields.sf = opnd.opnd0[8+`EXEC_SF_BIT];
        flags.fields.zf = opnd.opnd0[8+`EXEC_ZF_BIT];
        flags.fields.af = opnd.opnd0[8+`EXEC_AF_BIT];
        flags.fields.pf = opnd.opnd0[8+`EXEC_PF_BIT];
        flags.fields.cf = opnd.opnd0[8+`EXEC_CF_BIT];
      end
      default: opnd0_w = opnd.opnd0;
    endcase
  end

endmodule

/* verilog/cfu.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module cfu import exec_pkg::*; (
  exec_opnd_if.unit               opnd,
  input  logic [`EXEC_WORD_W-1:0] alu_result,
  output logic [`EXEC_WORD_W-1:0] next_eip
);

  logic [`EXEC_WORD_W-1:0] seq_eip;
  logic                    ecx_zero;

  // Fall-through address
  assign seq_eip = opnd.eip + {{(`EXEC_WORD_W-4){1'b0}}, opnd.instr_len};

  // LOOP decrements ECX first, so test the ALU result
  assign ecx_zero = (opnd.cmd == CMD_LOOP) ? (alu_result == '0) : opnd.ecx_is_zero;

  always_comb begin
    next_eip = seq_eip;
    case (opnd.cmd)
      // RET target is the popped value in opnd0
      CMD_JMP, CMD_CALL, CMD_RET: next_eip = opnd.opnd0;
      CMD_JZ: begin
        if (opnd.eflags.fields.zf) begin
          next_eip = opnd.opnd0;
        end
      end
      CMD_JNZ: begin
        if (!opnd.eflags.fields.zf) begin
          next_eip = opnd.opnd0;
        end
      end
      CMD_JC: begin
        if (opnd.eflags.fields.cf) begin
          next_eip = opnd.opnd0;
        end
      end
      CMD_LOOP: begin
        if (!ecx_zero) begin
          next_eip = opnd.opnd0;
        end
      end
      default: next_eip = seq_eip;
    endcase
  end

endmodule

/* verilog/execute.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module execute import exec_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic [6:0]              opc,
  input  logic [`EXEC_WORD_W-1:0] eflags,
  input  logic [`EXEC_WORD_W-1:0] eip,
  input  logic [3:0]              instr_len,
  input  logic                    ecx_is_zero,
  input  logic [`EXEC_WORD_W-1:0] opnd0_r,
  input  logic [`EXEC_WORD_W-1:0] opnd1_r,
  input  logic [`EXEC_WORD_W-1:0] opnd2_r,
  output logic [`EXEC_WORD_W-1:0] o_eflags,
  output logic [`EXEC_WORD_W-1:0] next_eip,
  output logic [`EXEC_WORD_W-1:0] opnd0_w,
  output logic [`EXEC_WORD_W-1:0] opnd1_w,
  output logic                    done,
  output logic                    busy
);

  localparam int W = `EXEC_WORD_W;

  logic         div_load;
  logic         div_step;
  logic         div_last;
  logic         capture;
  alu_op_e      alu_op;
  logic         alu_use_carry;
  logic         alu_adjust;
  logic         is_alu;
  logic         is_mfu;
  logic         is_div;
  logic         keep_opnd0;
  logic [W-1:0] alu_result;
  eflags_u      alu_flags;
  logic [W-1:0] quotient;
  logic [W-1:0] remainder;
  logic [W-1:0] mfu_opnd0_w;
  logic [W-1:0] mfu_opnd1_w;
  eflags_u      mfu_flags;
  logic [W-1:0] cfu_eip;
  logic [W-1:0] sel_opnd0;
  logic [W-1:0] sel_opnd1;
  eflags_u      sel_flags;

  exec_opnd_if opnd_if ();

  exec_seq seq_i (
    .clk(clk), .rst_n(rst_n), .start(start), .cmd(exec_cmd_e'(opc)),
    .eflags(eflags), .eip(eip), .instr_len(instr_len), .ecx_is_zero(ecx_is_zero),
    .opnd0_r(opnd0_r), .opnd1_r(opnd1_r), .opnd2_r(opnd2_r), .div_last(div_last),
    .opnd(opnd_if.seq), .div_load(div_load), .div_step(div_step),
    .capture(capture), .busy(busy)
  );

  div_step_counter div_cnt_i (
    .clk(clk), .rst_n(rst_n), .load(div_load), .step(div_step), .last(div_last)
  );

  // Decode of the latched command into ALU control and result class
  always_comb begin
    alu_op = ALU_PASS;
    case (opnd_if.cmd)
      CMD_ADD, CMD_ADC, CMD_INC, CMD_POP, CMD_RET: alu_op = ALU_ADD;
      CMD_SUB, CMD_SBB, CMD_DEC, CMD_CMP,
      CMD_PUSH, CMD_CALL, CMD_LOOP:                alu_op = ALU_SUB;
      CMD_AND, CMD_TEST:                           alu_op = ALU_AND;
      CMD_OR:                                      alu_op = ALU_OR;
      CMD_XOR:                                     alu_op = ALU_XOR;
      CMD_NOT:                                     alu_op = ALU_NOT;
      CMD_SHL:                                     alu_op = ALU_SHL;
      CMD_SHR:                                     alu_op = ALU_SHR;
      CMD_ROL:                                     alu_op = ALU_ROL;
      CMD_ROR:                                     alu_op = ALU_ROR;
      default:                                     alu_op = ALU_PASS;
    endcase
  end

  assign alu_use_carry = (opnd_if.cmd == CMD_ADC) || (opnd_if.cmd == CMD_SBB);
  // Stack pointer and ECX adjusts
  assign alu_adjust    = opnd_if.cmd inside {CMD_PUSH, CMD_POP, CMD_CALL, CMD_RET, CMD_LOOP};
  assign is_alu        = opnd_if.cmd inside {[CMD_ADD:CMD_ROR]};
  assign is_mfu        = opnd_if.cmd inside {[CMD_MOV:CMD_SAHF]};
  assign is_div        = (opnd_if.cmd == CMD_DIV);
  // Compare and test only produce flags
  assign keep_opnd0    = (opnd_if.cmd == CMD_CMP) || (opnd_if.cmd == CMD_TEST);

  alu alu_i (
    .op(alu_op), .opnd(opnd_if.unit), .use_carry(alu_use_carry), .adjust(alu_adjust),
    .result(alu_result), .flags(alu_flags)
  );

  div_unit div_i (
    .clk(clk), .rst_n(rst_n), .load(div_load), .step(div_step), .opnd(opnd_if.unit),
    .quotient(quotient), .remainder(remainder)
  );

  move_flag_unit mfu_i (
    .opnd(opnd_if.unit), .opnd0_w(mfu_opnd0_w), .opnd1_w(mfu_opnd1_w), .flags(mfu_flags)
  );

  cfu cfu_i (
    .opnd(opnd_if.unit), .alu_result(alu_result), .next_eip(cfu_eip)
  );

  // POP already carries the popped value in opnd0, so it falls through
  assign sel_opnd0 = (is_alu && !keep_opnd0) ? alu_result  :
                     is_mfu                  ? mfu_opnd0_w :
                     is_div                  ? quotient    :
                                               opnd_if.opnd0;

  // New ESP or ECX goes back through opnd1
  assign sel_opnd1 = alu_adjust ? alu_result  :
                     is_mfu     ? mfu_opnd1_w :
                     is_div     ? remainder   :
                                  opnd_if.opnd1;

  assign sel_flags = is_alu ? alu_flags :
                     is_mfu ? mfu_flags :
                              opnd_if.eflags;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_eflags <= '0;
      next_eip <= '0;
      opnd0_w  <= '0;
      opnd1_w  <= '0;
      done     <= 1'b0;
    end else begin
      done <= capture;
      // Outputs hold between commands
      if (capture) begin
        o_eflags <= sel_flags.raw;
        next_eip <= cfu_eip;
        opnd0_w  <= sel_opnd0;
        opnd1_w  <= sel_opnd1;
      end
    end
  end

endmodule

/* test/execute_tb.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module execute_tb import exec_pkg::*; ();

  localparam int W = `EXEC_WORD_W;
  // Upper bound on issued commands, each given 40 cycles
  localparam int N_CMDS      = 240;
  localparam int TIMEOUT_CYC = N_CMDS * 40;

  // Expected outputs of one command
  typedef struct packed {
    logic [W-1:0] flags;
    logic [W-1:0] eip;
    logic [W-1:0] w0;
    logic [W-1:0] w1;
  } exp_t;

  logic         clk;
  logic         rst_n;
  logic         start;
  logic [6:0]   opc;
  logic [W-1:0] eflags;
  logic [W-1:0] eip;
  logic [3:0]   instr_len;
  logic         ecx_is_zero;
  logic [W-1:0] opnd0_r;
  logic [W-1:0] opnd1_r;
  logic [W-1:0] opnd2_r;
  logic [W-1:0] o_eflags;
  logic [W-1:0] next_eip;
  logic [W-1:0] opnd0_w;
  logic [W-1:0] opnd1_w;
  logic         done;
  logic         busy;

  logic [31:0] rng    = 32'h40a8_1503;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  exp_t        exp_res;

  execute execute_i (
    .clk(clk), .rst_n(rst_n), .start(start), .opc(opc), .eflags(eflags), .eip(eip),
    .instr_len(instr_len), .ecx_is_zero(ecx_is_zero), .opnd0_r(opnd0_r),
    .opnd1_r(opnd1_r), .opnd2_r(opnd2_r), .o_eflags(o_eflags), .next_eip(next_eip),
    .opnd0_w(opnd0_w), .opnd1_w(opnd1_w), .done(done), .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hard stop if the DUT never finishes
  initial begin
    while (cycles < TIMEOUT_CYC) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: simulation still running after %0d cycles", cycles);
    $display("Done: errors found");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic compare_word(input string what, input logic [W-1:0] got,
                              input logic [W-1:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED at %0t ns: %s got %h, expected %h", $time, what, got, want);
    end
  endtask

  // Reference model of one command
  function automatic exp_t expected_result(input exec_cmd_e cmd, input logic [W-1:0] fl,
      input logic [W-1:0] pc, input logic [3:0] len, input logic [W-1:0] o0,
      input logic [W-1:0] o1, input logic [W-1:0] o2);
    exp_t         e;
    eflags_u      f;
    logic [W:0]   wide;
    logic [W-1:0] r;
    int           n;
    logic         cin;
    longint       sres;
    logic         zsp;
    f.raw = fl;
    r     = o0;
    e.w0  = o0;
    e.w1  = o1;
    e.eip = pc + {{(W-4){1'b0}}, len};
    n     = int'(o1[4:0]);
    cin   = ((cmd == CMD_ADC) || (cmd == CMD_SBB)) && f.fields.cf;
    zsp   = 1'b0;
    case (cmd)
      CMD_ADD, CMD_ADC, CMD_INC: begin
        wide        = {1'b0, o0} + {1'b0, o1} + {{W{1'b0}}, cin};
        r           = wide[W-1:0];
        sres        = longint'($signed(o0)) + longint'($signed(o1)) + (cin ? 1 : 0);
        f.fields.cf = wide[W];
        // Overflow when the true signed sum does not fit a word
        f.fields.of = (sres != longint'($signed(r)));
        zsp         = 1'b1;
      end
      CMD_SUB, CMD_SBB, CMD_DEC, CMD_CMP: begin
        r           = o0 - o1 - {{(W-1){1'b0}}, cin};
        sres        = longint'($signed(o0)) - longint'($signed(o1)) - (cin ? 1 : 0);
        // Borrow when the unsigned subtrahend is larger
        f.fields.cf = ({1'b0, o0} < ({1'b0, o1} + {{W{1'b0}}, cin}));
        f.fields.of = (sres != longint'($signed(r)));
        zsp         = 1'b1;
      end
      CMD_AND, CMD_OR, CMD_XOR, CMD_TEST: begin
        r = (cmd == CMD_OR) ? (o0 | o1) : (cmd == CMD_XOR) ? (o0 ^ o1) : (o0 & o1);
        f.fields.cf = 1'b0;
        f.fields.of = 1'b0;
        zsp         = 1'b1;
      end
      CMD_NOT: r = ~o0;
      CMD_SHL: begin
        r = o0 << n;
        if (n != 0) begin
          f.fields.cf = o0[W-n];
          zsp         = 1'b1;
        end
      end
      CMD_SHR: begin
        r = o0 >> n;
        if (n != 0) begin
          f.fields.cf = o0[n-1];
          zsp         = 1'b1;
        end
      end
      CMD_ROL, CMD_ROR: begin
        // Bit i moves n places up for ROL, down for ROR
        for (int i = 0; i < W; i++) begin
          if (cmd == CMD_ROL) begin
            r[(i + n) % W] = o0[i];
          end else begin
            r[(i + W - n) % W] = o0[i];
          end
        end
        if (n != 0) begin
          f.fields.cf = (cmd == CMD_ROL) ? r[0] : r[W-1];
        end
      end
      CMD_PUSH, CMD_CALL, CMD_LOOP: e.w1 = o1 - o2;
      CMD_POP, CMD_RET:             e.w1 = o1 + o2;
      CMD_MOV:  e.w0 = o1;
      CMD_XCHG: begin
        e.w0 = o1;
        e.w1 = o0;
      end
      CMD_CDQ: e.w1 = o0[W-1] ? '1 : '0;
      CMD_STC: f.fields.cf = 1'b1;
      CMD_CLC: f.fields.cf = 1'b0;
      CMD_STD: f.fields.df = 1'b1;
      CMD_CLD: f.fields.df = 1'b0;
      // AH layout is SF ZF 0 AF 0 PF 1 CF
      CMD_LAHF: e.w0[15:8] = {f.fields.sf, f.fields.zf, 1'b0, f.fields.af, 1'b0,
                              f.fields.pf, 1'b1, f.fields.cf};
      CMD_SAHF: begin
        f.fields.sf = o0[15];
        f.fields.zf = o0[14];
        f.fields.af = o0[12];
        f.fields.pf = o0[10];
        f.fields.cf = o0[8];
      end
      CMD_DIV: begin
        if (o1 == '0) begin
          e.w0 = '1;
          e.w1 = o0;
        end else begin
          e.w0 = o0 / o1;
          e.w1 = o0 % o1;
        end
      end
      default: ;
    endcase
    if (zsp) begin
      f.fields.zf = (r == '0);
      f.fields.sf = r[W-1];
      f.fields.pf = (($countones(r[7:0]) % 2) == 0);
    end
    // CMP and TEST only report flags
    if ((cmd inside {[CMD_ADD:CMD_ROR]}) && !(cmd inside {CMD_CMP, CMD_TEST})) begin
      e.w0 = r;
    end
    case (cmd)
      CMD_JMP, CMD_CALL, CMD_RET: e.eip = o0;
      CMD_JZ: begin
        if (f.fields.zf) begin
          e.eip = o0;
        end
      end
      CMD_JNZ: begin
        if (!f.fields.zf) begin
          e.eip = o0;
        end
      end
      CMD_JC: begin
        if (f.fields.cf) begin
          e.eip = o0;
        end
      end
      // Taken while the decremented ECX is nonzero
      CMD_LOOP: begin
        if (e.w1 != '0) begin
          e.eip = o0;
        end
      end
      default: ;
    endcase
    e.flags = f.raw;
    return e;
  endfunction

  // Compare on every done pulse
  always @(negedge clk) begin
    if (rst_n && done) begin
      compare_word("o_eflags", o_eflags, exp_res.flags);
      compare_word("next_eip", next_eip, exp_res.eip);
      compare_word("opnd0_w", opnd0_w, exp_res.w0);
      compare_word("opnd1_w", opnd1_w, exp_res.w1);
    end
  end

  // One start pulse, then wait for done and measure the latency
  task automatic issue_command(input exec_cmd_e cmd, input logic [W-1:0] fl,
      input logic [W-1:0] o0, input logic [W-1:0] o1, input logic [W-1:0] o2,
      input logic poke);
    logic [W-1:0] pc;
    logic [3:0]   len;
    int           lat;
    int           want;
    logic         got;
    @(posedge clk);
    pc      = next_rand();
    len     = 4'(next_rand() % 15 + 1);
    want    = (cmd == CMD_DIV) ? `EXEC_DIV_STEPS + 2 : 1;
    exp_res = expected_result(cmd, fl, pc, len, o0, o1, o2);
    start       <= 1'b1;
    opc         <= cmd;
    eflags      <= fl;
    eip         <= pc;
    instr_len   <= len;
    ecx_is_zero <= (o1 == '0);
    opnd0_r     <= o0;
    opnd1_r     <= o1;
    opnd2_r     <= o2;
    @(posedge clk);
    start <= 1'b0;
    lat = 0;
    got = 1'b0;
    while (!got) begin
      @(negedge clk);
      if (done) begin
        got = 1'b1;
      end else begin
        lat++;
        compare_word("busy while running", W'(busy), W'(1));
        @(posedge clk);
        // Second start while busy must be dropped
        start <= poke && (lat == 3);
        if (poke && (lat == 3)) begin
          opc     <= CMD_ADD;
          opnd0_r <= next_rand();
          opnd1_r <= next_rand();
        end
      end
    end
    compare_word("start to done cycles", W'(lat), W'(want));
  endtask

  // Idle cycles keep outputs and show no stray done
  task automatic check_hold(input int n);
    repeat (n) begin
      @(negedge clk);
      compare_word("done while idle", W'(done), W'(0));
      compare_word("busy while idle", W'(busy), W'(0));
      compare_word("held o_eflags", o_eflags, exp_res.flags);
      compare_word("held next_eip", next_eip, exp_res.eip);
      compare_word("held opnd0_w", opnd0_w, exp_res.w0);
      compare_word("held opnd1_w", opnd1_w, exp_res.w1);
    end
  endtask

  initial begin
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] fl;
    exec_cmd_e    cmd;
    rst_n       = 1'b0;
    start       = 1'b0;
    opc         = 7'd0;
    eflags      = '0;
    eip         = '0;
    instr_len   = 4'd0;
    ecx_is_zero = 1'b0;
    opnd0_r     = '0;
    opnd1_r     = '0;
    opnd2_r     = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_word("done after reset", W'(done), W'(0));
    compare_word("busy after reset", W'(busy), W'(0));
    compare_word("o_eflags after reset", o_eflags, '0);
    compare_word("next_eip after reset", next_eip, '0);
    compare_word("opnd0_w after reset", opnd0_w, '0);
    compare_word("opnd1_w after reset", opnd1_w, '0);

    // Random ALU work, shift counts 0 and 31 up front
    for (int k = CMD_ADD; k <= CMD_ROR; k++) begin
      cmd = exec_cmd_e'(k);
      for (int i = 0; i < 8; i++) begin
        a = next_rand();
        b = next_rand();
        if (i == 0) begin
          b[4:0] = 5'd0;
        end else if (i == 1) begin
          b[4:0] = 5'd31;
        end
        if ((cmd == CMD_INC) || (cmd == CMD_DEC)) begin
          b = 32'd1;
        end
        issue_command(cmd, next_rand(), a, b, next_rand(), 1'b0);
      end
    end
    // Carry and overflow corners
    issue_command(CMD_ADD, '0, 32'h7fff_ffff, 32'd1, '0, 1'b0);
    issue_command(CMD_ADD, '0, 32'hffff_ffff, 32'd1, '0, 1'b0);
    issue_command(CMD_SUB, '0, 32'd0, 32'd1, '0, 1'b0);
    issue_command(CMD_SBB, 32'h0000_0001, 32'd0, 32'd0, '0, 1'b0);
    issue_command(CMD_ADC, 32'h0000_0001, 32'hffff_fffe, 32'd1, '0, 1'b0);

    // Stack and ECX adjusts
    for (int k = CMD_PUSH; k <= CMD_LOOP; k++) begin
      for (int i = 0; i < 4; i++) begin
        issue_command(exec_cmd_e'(k), next_rand(), next_rand(), next_rand(),
                      (i < 2) ? 32'd4 : next_rand(), 1'b0);
      end
    end

    // Moves and direct flag commands
    for (int k = CMD_MOV; k <= CMD_SAHF; k++) begin
      for (int i = 0; i < 4; i++) begin
        issue_command(exec_cmd_e'(k), next_rand(), next_rand(), next_rand(), next_rand(), 1'b0);
      end
    end
    check_hold(3);

    // Control flow, conditions taken and not taken
    issue_command(CMD_NOP, next_rand(), next_rand(), next_rand(), next_rand(), 1'b0);
    issue_command(CMD_JMP, next_rand(), next_rand(), next_rand(), next_rand(), 1'b0);
    for (int k = CMD_JZ; k <= CMD_JC; k++) begin
      for (int i = 0; i < 2; i++) begin
        fl = next_rand();
        fl[`EXEC_ZF_BIT] = i[0];
        fl[`EXEC_CF_BIT] = i[0];
        issue_command(exec_cmd_e'(k), fl, next_rand(), next_rand(), next_rand(), 1'b0);
      end
    end
    issue_command(CMD_CALL, next_rand(), next_rand(), next_rand(), 32'd4, 1'b0);
    issue_command(CMD_RET, next_rand(), next_rand(), next_rand(), 32'd4, 1'b0);
    issue_command(CMD_LOOP, next_rand(), next_rand(), 32'd2, 32'd1, 1'b0);
    issue_command(CMD_LOOP, next_rand(), next_rand(), 32'd5, 32'd1, 1'b0);
    issue_command(CMD_LOOP, next_rand(), next_rand(), 32'd1, 32'd1, 1'b0);
    check_hold(2);

    // Divide with random, small and zero divisors
    for (int i = 0; i < 6; i++) begin
      b = next_rand() >> (i * 5);
      issue_command(CMD_DIV, next_rand(), next_rand(), b, next_rand(), 1'b0);
    end
    issue_command(CMD_DIV, next_rand(), next_rand(), '0, next_rand(), 1'b0);
    issue_command(CMD_DIV, next_rand(), 32'h8000_0001, '0, next_rand(), 1'b0);
    issue_command(CMD_DIV, next_rand(), next_rand(), 32'd7, next_rand(), 1'b1);
    check_hold(4);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+verilog
verilog/exec_pkg.sv
verilog/exec_opnd_if.sv
verilog/exec_seq.sv
verilog/div_step_counter.sv
verilog/alu.sv
verilog/div_unit.sv
verilog/move_flag_unit.sv
verilog/cfu.sv
verilog/execute.sv
test/execute_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary -Wno-fatal --top-module execute_tb -f src.f -Mdir obj_dir -o execute_sim \
  && out=$(./obj_dir/execute_sim) \
  && printf '%s\n' "$out" \
  && printf '%s\n' "$out" | grep -q "Done: no errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
